// ==== build.f ====
logic/status_pkg.sv
logic/status_wr_channel.sv
logic/status_rd_channel.sv
logic/status_reg_file.sv
logic/status_slave_top.sv
verification/status_slave_props.sv
verification/status_slave_tb.sv

// ==== Bender.yml ====
package:
  name: status_slave

sources:
  - logic/status_pkg.sv
  - logic/status_wr_channel.sv
  - logic/status_rd_channel.sv
  - logic/status_reg_file.sv
  - logic/status_slave_top.sv
  - target: test
    files:
      - verification/status_slave_props.sv
      - verification/status_slave_tb.sv

// ==== verification/status_slave_tb.sv ====
`timescale 1ns/10ps

module status_slave_tb;

    import status_pkg::*;

    localparam int MAX_CYCLES = 5000;                      // suite needs a few hundred cycles

    logic        clk = 1'b0;
    logic        STATUS_SLAVE_RSTN_SYNC;
    aw_t         aw;
    logic        aw_valid;
    logic        aw_ready;
    w_t          w;
    logic        w_valid;
    logic        w_ready;
    b_t          b;
    logic        b_valid;
    logic        b_ready;
    ar_t         ar;
    logic        ar_valid;
    logic        ar_ready;
    r_t          r;
    logic        r_valid;
    logic        r_ready;
    sys_status_t sys_status;
    net_cfg_t    default_cfg;
    logic [15:0] axi_master_reset;
    logic [15:0] axi_slave_reset;
    logic [7:0]  power_status;
    logic [7:0]  power_reset;
    net_cfg_t    net_cfg;

    int          cycles = 0;
    logic [31:0] rng = 32'h17dc;
    logic [31:0] wdata_q[$];                               // beats of the next write burst
    logic [3:0]  wstrb_q[$];
    r_t          rbeat_q[$];                               // beats of the last read burst
    logic [47:0] m_mac;                                    // expected register contents
    logic [31:0] m_ip;
    logic [31:0] m_host;
    logic [7:0]  m_power;
    logic [15:0] m_mrst;                                   // expected pulses this cycle
    logic [15:0] m_srst;
    logic [7:0]  m_prst;

    status_slave_top u_status_slave_top (.*);

    always #50 clk = ~clk;

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles == MAX_CYCLES) begin
            $display("Timeout: tests did not finish within %0d clock cycles", MAX_CYCLES);
            $display("Simulation failed");
            $fatal(1, "timeout");
        end
    end

    always @(posedge clk) begin
        if (u_status_slave_top.u_status_slave_props.fail_count != 0) begin
            $display("A handshake assertion failed before %0t", $time);
            $display("Simulation failed");
            $fatal(1, "handshake assertion failed");
        end
    end

    function automatic logic [31:0] xorshift32(input logic [31:0] x);
        logic [31:0] s;
        s = x ^ (x << 13);
        s = s ^ (s >> 17);
        return s ^ (s << 5);
    endfunction

    function logic pick_ready(input bit stall);
        rng = xorshift32(rng);
        return !stall || rng[0];
    endfunction

    function automatic logic is_readable(input logic [31:0] addr);
        return addr <= 32'hA && addr != 32'h1 && addr != 32'h6;  // 0x1, 0x6 write only
    endfunction

    function automatic logic is_writable(input logic [31:0] addr);
        return addr inside {32'h1, 32'h5, 32'h6, [32'h7:32'hA]};
    endfunction

    function automatic logic [31:0] expected_data(input logic [31:0] addr);
        case (addr)
            32'h0: return {sys_status.master_rstn_status, sys_status.slave_rstn_status};
            32'h2: return sys_status.uid_high;
            32'h3: return sys_status.uid_middle;
            32'h4: return sys_status.uid_low;
            32'h5: return {24'h0, m_power};
            32'h7: return {16'h0, m_mac[47:32]};
            32'h8: return m_mac[31:0];
            32'h9: return m_ip;
            32'hA: return m_host;
            default: return 32'hFFFF_FFFF;
        endcase
    endfunction

    task automatic check_equal(input string name, input logic [127:0] actual,
                               input logic [127:0] expected);
        if (actual !== expected) begin
            $display("Mismatch at %0t: %s = %0h, expected %0h", $time, name, actual, expected);
            $display("Simulation failed");
            $fatal(1, "check of %s failed", name);
        end
    endtask

    // model update for the bytes each register really holds
    task automatic apply_write(input logic [31:0] addr, input logic [31:0] data,
                               input logic [3:0] strb);
        for (int i = 0; i < 4; i++) begin
            if (strb[i]) begin
                case (addr)
                    32'h1: begin
                        if (i >= 2) m_mrst[8*i-16 +: 8] = data[8*i +: 8];
                        else m_srst[8*i +: 8] = data[8*i +: 8];
                    end
                    32'h5: if (i == 0) m_power = data[7:0];
                    32'h6: if (i == 0) m_prst = data[7:0];
                    32'h7: if (i < 2) m_mac[32+8*i +: 8] = data[8*i +: 8];
                    32'h8: m_mac[8*i +: 8] = data[8*i +: 8];
                    32'h9: m_ip[8*i +: 8] = data[8*i +: 8];
                    32'hA: m_host[8*i +: 8] = data[8*i +: 8];
                    default: ;
                endcase
            end
        end
    endtask

    task automatic check_outputs();
        check_equal("net_cfg.mac", net_cfg.mac, m_mac);
        check_equal("net_cfg.ip", net_cfg.ip, m_ip);
        check_equal("net_cfg.host_ip", net_cfg.host_ip, m_host);
        check_equal("power_status", power_status, m_power);
        check_equal("axi_master_reset", axi_master_reset, m_mrst);
        check_equal("axi_slave_reset", axi_slave_reset, m_srst);
        check_equal("power_reset", power_reset, m_prst);
    endtask

    task automatic queue_beat(input logic [31:0] data, input logic [3:0] strb);
        wdata_q.push_back(data);
        wstrb_q.push_back(strb);
    endtask

    // sends the queued beats and checks the pulses and the B response
    task automatic axi_write(input logic [3:0] id, input logic [31:0] addr, input burst_e burst,
                             input bit stall);
        logic [31:0] beat_addr;
        logic        burst_ok;
        logic        exp_err;
        logic        done;
        beat_addr = addr;
        burst_ok  = (burst == FIXED) || (burst == INCR);
        exp_err   = !burst_ok;
        aw.id     = id;
        aw.addr   = addr;
        aw.burst  = burst;
        aw_valid  = 1'b1;
        while (!aw_ready) @(negedge clk);                  // transfer at the next rising edge
        @(negedge clk);
        aw_valid = 1'b0;
        foreach (wdata_q[i]) begin
            w.data  = wdata_q[i];
            w.strb  = wstrb_q[i];
            w.last  = (i == wdata_q.size() - 1);
            w_valid = 1'b1;
            while (!w_ready) @(negedge clk);
            @(negedge clk);
            w_valid = 1'b0;
            m_mrst  = '0;
            m_srst  = '0;
            m_prst  = '0;
            if (!is_writable(beat_addr)) exp_err = 1'b1;
            else if (burst_ok) apply_write(beat_addr, wdata_q[i], wstrb_q[i]);
            check_outputs();                               // cycle right after the beat
            if (burst == INCR) beat_addr++;
        end
        m_mrst = '0;
        m_srst = '0;
        m_prst = '0;
        done   = 1'b0;
        while (!done) begin
            b_ready = pick_ready(stall);
            if (b_valid && b_ready) begin
                check_equal("b.id", b.id, id);
                check_equal("b.resp", b.resp, exp_err ? SLVERR : OKAY);
                done = 1'b1;
            end
            @(negedge clk);
        end
        b_ready = 1'b0;
        check_outputs();
        wdata_q.delete();
        wstrb_q.delete();
    endtask

    task automatic axi_read(input logic [3:0] id, input logic [31:0] addr, input logic [7:0] len,
                            input burst_e burst, input bit stall);
        logic done;
        ar.id    = id;
        ar.addr  = addr;
        ar.len   = len;
        ar.burst = burst;
        ar_valid = 1'b1;
        while (!ar_ready) @(negedge clk);
        @(negedge clk);
        ar_valid = 1'b0;
        rbeat_q.delete();
        done = 1'b0;
        while (!done) begin
            r_ready = pick_ready(stall);
            if (r_valid && r_ready) begin
                rbeat_q.push_back(r);
                done = r.last;
            end
            @(negedge clk);
        end
        r_ready = 1'b0;
    endtask

    task automatic check_read(input logic [3:0] id, input logic [31:0] addr,
                              input logic [7:0] len, input burst_e burst, input bit stall);
        logic [31:0] beat_addr;
        logic        err;
        axi_read(id, addr, len, burst, stall);
        check_equal("r beat count", rbeat_q.size(), len + 1);
        beat_addr = addr;
        err       = !(burst == FIXED || burst == INCR);
        foreach (rbeat_q[i]) begin
            err = err || !is_readable(beat_addr);          // sticky over the burst
            check_equal($sformatf("r.id[%0d]", i), rbeat_q[i].id, id);
            check_equal($sformatf("r.data[%0d]", i), rbeat_q[i].data, expected_data(beat_addr));
            check_equal($sformatf("r.resp[%0d]", i), rbeat_q[i].resp, err ? SLVERR : OKAY);
            check_equal($sformatf("r.last[%0d]", i), rbeat_q[i].last, i == len);
            if (burst == INCR) beat_addr++;
        end
    endtask

    task automatic reset_values();
        check_equal("net_cfg", net_cfg, default_cfg);
        check_outputs();
        check_equal("aw_ready", aw_ready, 1'b1);
        check_equal("ar_ready", ar_ready, 1'b1);
        check_equal("w_ready", w_ready, 1'b0);
        check_equal("b_valid", b_valid, 1'b0);
        check_equal("r_valid", r_valid, 1'b0);
    endtask

    task automatic strobed_writes();
        queue_beat(32'hDEAD_BEEF, 4'b0101);
        axi_write(4'h3, 32'h9, INCR, 1'b0);
        queue_beat(32'h0A0B_0C0D, 4'b1000);
        axi_write(4'h5, 32'hA, FIXED, 1'b0);
        queue_beat(32'hFFFF_ABCD, 4'b0110);                // byte 2 lies above MAC high
        axi_write(4'h6, 32'h7, INCR, 1'b0);
        queue_beat(32'h0000_A55A, 4'b0001);
        axi_write(4'h7, 32'h5, FIXED, 1'b0);
        queue_beat(32'h9876_0000, 4'b1100);
        axi_write(4'h8, 32'h8, INCR, 1'b0);
        check_read(4'h1, 32'h7, 8'd3, INCR, 1'b0);
        check_read(4'h2, 32'h5, 8'd0, FIXED, 1'b0);
    endtask

    task automatic read_bursts();
        check_read(4'h2, 32'h2, 8'd2, INCR, 1'b0);
        check_read(4'h9, 32'h0, 8'd1, FIXED, 1'b0);
    endtask

    task automatic reset_pulses();
        queue_beat(32'h8001_0203, 4'hF);
        axi_write(4'hA, 32'h1, INCR, 1'b0);
        queue_beat(32'hFFFF_FFFF, 4'b0100);
        axi_write(4'hB, 32'h1, FIXED, 1'b0);
        queue_beat(32'h0000_00C5, 4'h1);
        queue_beat(32'h0000_003A, 4'h1);                   // back to back pulses
        axi_write(4'hC, 32'h6, FIXED, 1'b0);
    endtask

    task automatic error_responses();
        queue_beat(32'h1111_2222, 4'hF);
        axi_write(4'hC, 32'h3, INCR, 1'b0);
        queue_beat(32'h0BAD_0BAD, 4'hF);
        axi_write(4'hD, 32'h9, WRAP, 1'b0);
        queue_beat(32'h0BAD_0BAD, 4'hF);
        axi_write(4'h1, 32'hA, RESERVED, 1'b0);
        queue_beat(32'h3333_3333, 4'hF);
        queue_beat(32'h4444_4444, 4'hF);
        queue_beat(32'h0000_0077, 4'hF);                   // legal beat still lands
        axi_write(4'h2, 32'h3, INCR, 1'b0);
        check_read(4'h4, 32'h2, 8'd0, WRAP, 1'b0);
        check_read(4'h6, 32'h9, 8'd2, INCR, 1'b0);
        check_read(4'h7, 32'h1, 8'd0, FIXED, 1'b0);
    endtask

    task automatic back_pressure();
        for (int i = 0; i < 4; i++) begin
            rng = xorshift32(rng);
            queue_beat(rng, 4'hF);
        end
        axi_write(4'hE, 32'h7, INCR, 1'b1);
        check_read(4'hF, 32'h7, 8'd3, INCR, 1'b1);
        check_read(4'h0, 32'h0, 8'd5, INCR, 1'b1);
    endtask

    initial begin
        STATUS_SLAVE_RSTN_SYNC = 1'b0;
        aw          = '0;
        aw_valid    = 1'b0;
        w           = '0;
        w_valid     = 1'b0;
        b_ready     = 1'b0;
        ar          = '0;
        ar_valid    = 1'b0;
        r_ready     = 1'b0;
        sys_status  = {16'hA5C3, 16'h3C5A, 32'h1122_3344, 32'h5566_7788, 32'h99AA_BBCC};
        default_cfg = {48'h0200_1234_5678, 32'hC0A8_0164, 32'hC0A8_0101};
        m_mac       = default_cfg.mac;
        m_ip        = default_cfg.ip;
        m_host      = default_cfg.host_ip;
        m_power     = '0;
        m_mrst      = '0;
        m_srst      = '0;
        m_prst      = '0;
        repeat (10) @(negedge clk);
        STATUS_SLAVE_RSTN_SYNC = 1'b1;
        @(negedge clk);
        reset_values();
        strobed_writes();
        read_bursts();
        reset_pulses();
        error_responses();
        back_pressure();
        if (u_status_slave_top.u_status_slave_props.fail_count == 0) begin
            $display("Simulation completed successfully");
            $finish;
        end else begin
            $display("%0d handshake assertions failed",
                     u_status_slave_top.u_status_slave_props.fail_count);
            $display("Simulation failed");
            $fatal(1, "handshake assertions failed");
        end
    end

endmodule

// ==== verification/status_slave_props.sv ====
`timescale 1ns/10ps

module status_slave_props (
    input logic                clk,
    input logic                STATUS_SLAVE_RSTN_SYNC,
    input logic                aw_ready,
    input status_pkg::b_t      b,
    input logic                b_valid,
    input logic                b_ready,
    input status_pkg::r_t      r,
    input logic                r_valid,
    input logic                r_ready
);

    int fail_count = 0;                                    // failed assertions so far

    b_hold: assert property (@(posedge clk) disable iff (!STATUS_SLAVE_RSTN_SYNC)
        b_valid && !b_ready |=> b_valid && $stable(b))
        else begin
            fail_count++;
            $error("b_valid or b changed while b_ready was low");
        end

    r_hold: assert property (@(posedge clk) disable iff (!STATUS_SLAVE_RSTN_SYNC)
        r_valid && !r_ready |=> r_valid && $stable(r))
        else begin
            fail_count++;
            $error("r_valid or r changed while r_ready was low");
        end

    last_with_valid: assert property (@(posedge clk) disable iff (!STATUS_SLAVE_RSTN_SYNC)
        r.last |-> r_valid)
        else begin
            fail_count++;
            $error("r.last high without r_valid");
        end

    no_aw_during_b: assert property (@(posedge clk) disable iff (!STATUS_SLAVE_RSTN_SYNC)
        b_valid |-> !aw_ready)                             // one write burst in flight
        else begin
            fail_count++;
            $error("aw_ready high while b_valid pending");
        end

endmodule

bind status_slave_top status_slave_props u_status_slave_props (.*);

// ==== logic/status_slave_top.sv ====
`timescale 1ns/10ps

module status_slave_top (
    input  logic                    clk,
    input  logic                    STATUS_SLAVE_RSTN_SYNC,

    input  status_pkg::aw_t         aw,
    input  logic                    aw_valid,
    output logic                    aw_ready,
    input  status_pkg::w_t          w,
    input  logic                    w_valid,
    output logic                    w_ready,
    output status_pkg::b_t          b,
    output logic                    b_valid,
    input  logic                    b_ready,

    input  status_pkg::ar_t         ar,
    input  logic                    ar_valid,
    output logic                    ar_ready,
    output status_pkg::r_t          r,
    output logic                    r_valid,
    input  logic                    r_ready,

    input  status_pkg::sys_status_t sys_status,
    input  status_pkg::net_cfg_t    default_cfg,
    output logic [15:0]             axi_master_reset,
    output logic [15:0]             axi_slave_reset,
    output logic [7:0]              power_status,
    output logic [7:0]              power_reset,
    output status_pkg::net_cfg_t    net_cfg
);

    import status_pkg::*;

    reg_wr_t           reg_wr;                             // write channel to registers
    logic              wr_illegal;
    logic [ADDR_W-1:0] rd_addr;
    logic [DATA_W-1:0] rd_data;
    logic              rd_illegal;

    status_wr_channel u_status_wr_channel (
        .clk                    (clk),
        .STATUS_SLAVE_RSTN_SYNC (STATUS_SLAVE_RSTN_SYNC),
        .aw                     (aw),
        .aw_valid               (aw_valid),
        .aw_ready               (aw_ready),
        .w                      (w),
        .w_valid                (w_valid),
        .w_ready                (w_ready),
        .b                      (b),
        .b_valid                (b_valid),
        .b_ready                (b_ready),
        .reg_wr                 (reg_wr),
        .wr_illegal             (wr_illegal)
    );

    status_rd_channel u_status_rd_channel (
        .clk                    (clk),
        .STATUS_SLAVE_RSTN_SYNC (STATUS_SLAVE_RSTN_SYNC),
        .ar                     (ar),
        .ar_valid               (ar_valid),
        .ar_ready               (ar_ready),
        .r                      (r),
        .r_valid                (r_valid),
        .r_ready                (r_ready),
        .rd_addr                (rd_addr),
        .rd_data                (rd_data),
        .rd_illegal             (rd_illegal)
    );

    status_reg_file u_status_reg_file (
        .clk                    (clk),
        .STATUS_SLAVE_RSTN_SYNC (STATUS_SLAVE_RSTN_SYNC),
        .reg_wr                 (reg_wr),
        .wr_illegal             (wr_illegal),
        .rd_addr                (rd_addr),
        .rd_data                (rd_data),
        .rd_illegal             (rd_illegal),
        .sys_status             (sys_status),
        .default_cfg            (default_cfg),
        .axi_master_reset       (axi_master_reset),
        .axi_slave_reset        (axi_slave_reset),
        .power_status           (power_status),
        .power_reset            (power_reset),
        .net_cfg                (net_cfg)
    );

endmodule

// ==== logic/status_reg_file.sv ====
`timescale 1ns/10ps

module status_reg_file (
    input  logic                          clk,
    input  logic                          STATUS_SLAVE_RSTN_SYNC,
    input  status_pkg::reg_wr_t           reg_wr,
    output logic                          wr_illegal,
    input  logic [status_pkg::ADDR_W-1:0] rd_addr,
    output logic [status_pkg::DATA_W-1:0] rd_data,
    output logic                          rd_illegal,
    input  status_pkg::sys_status_t       sys_status,
    input  status_pkg::net_cfg_t          default_cfg,
    output logic [15:0]                   axi_master_reset,
    output logic [15:0]                   axi_slave_reset,
    output logic [7:0]                    power_status,
    output logic [7:0]                    power_reset,
    output status_pkg::net_cfg_t          net_cfg
);

    import status_pkg::*;

    logic [DATA_W-1:0] wr_mask;                            // strobes spread to bits

    function automatic logic [DATA_W-1:0] strb_mask(input logic [STRB_W-1:0] strb);
        logic [DATA_W-1:0] mask;
        for (int i = 0; i < STRB_W; i++) begin
            mask[8*i +: 8] = {8{strb[i]}};
        end
        return mask;
    endfunction

    // keep unstrobed bytes of a full word
    function automatic logic [DATA_W-1:0] merge_word(
        input logic [DATA_W-1:0] cur,
        input logic [DATA_W-1:0] data,
        input logic [DATA_W-1:0] mask
    );
        return (cur & ~mask) | (data & mask);
    endfunction

    assign wr_mask    = strb_mask(reg_wr.strb);
    assign wr_illegal = !addr_writable(reg_wr.addr);
    assign rd_illegal = !addr_readable(rd_addr);

    always_ff @(posedge clk or negedge STATUS_SLAVE_RSTN_SYNC) begin
        if (!STATUS_SLAVE_RSTN_SYNC) begin
            axi_master_reset <= '0;
            axi_slave_reset  <= '0;
            power_status     <= '0;
            power_reset      <= '0;
            net_cfg          <= default_cfg;                   // board defaults come back on reset
        end else begin
            axi_master_reset <= '0;                            // pulses last a single cycle
            axi_slave_reset  <= '0;
            power_reset      <= '0;
            if (reg_wr.valid) begin
                case (reg_wr.addr)
                    AXI_RESET: begin
                        axi_master_reset <= reg_wr.data[31:16] & wr_mask[31:16];
                        axi_slave_reset  <= reg_wr.data[15:0] & wr_mask[15:0];
                    end
                    POWER_STATUS: begin
                        power_status <= (power_status & ~wr_mask[7:0])
                                      | (reg_wr.data[7:0] & wr_mask[7:0]);
                    end
                    POWER_RESET: begin
                        power_reset <= reg_wr.data[7:0] & wr_mask[7:0];
                    end
                    MAC_HIGH: begin
                        net_cfg.mac[47:32] <= (net_cfg.mac[47:32] & ~wr_mask[15:0])
                                            | (reg_wr.data[15:0] & wr_mask[15:0]);
                    end
                    MAC_LOW: begin
                        net_cfg.mac[31:0] <= merge_word(net_cfg.mac[31:0], reg_wr.data, wr_mask);
                    end
                    DEV_IP: begin
                        net_cfg.ip <= merge_word(net_cfg.ip, reg_wr.data, wr_mask);
                    end
                    HOST_IP: begin
                        net_cfg.host_ip <= merge_word(net_cfg.host_ip, reg_wr.data, wr_mask);
                    end
                    default: begin
                    end                                        // read-only or unmapped
                endcase
            end
        end
    end

    always_comb begin
        case (rd_addr)
            AXI_RST_STATUS: rd_data = {sys_status.master_rstn_status,
                                       sys_status.slave_rstn_status};
            UID_HIGH:       rd_data = sys_status.uid_high;
            UID_MIDDLE:     rd_data = sys_status.uid_middle;
            UID_LOW:        rd_data = sys_status.uid_low;
            POWER_STATUS:   rd_data = {{(DATA_W-8){1'b0}}, power_status};
            MAC_HIGH:       rd_data = {{MAC_HI_PAD{1'b0}}, net_cfg.mac[47:32]};
            MAC_LOW:        rd_data = net_cfg.mac[31:0];
            DEV_IP:         rd_data = net_cfg.ip;
            HOST_IP:        rd_data = net_cfg.host_ip;
            default:        rd_data = UNMAPPED_DATA;           // holes and write-only regs
        endcase
    end

endmodule

// ==== logic/status_rd_channel.sv ====
`timescale 1ns/10ps

module status_rd_channel (
    input  logic                          clk,
    input  logic                          STATUS_SLAVE_RSTN_SYNC,
    input  status_pkg::ar_t               ar,
    input  logic                          ar_valid,
    output logic                          ar_ready,
    output status_pkg::r_t                r,
    output logic                          r_valid,
    input  logic                          r_ready,
    output logic [status_pkg::ADDR_W-1:0] rd_addr,
    input  logic [status_pkg::DATA_W-1:0] rd_data,
    input  logic                          rd_illegal
);

    import status_pkg::*;

    rd_state_e         state_q;
    rd_state_e         state_d;
    logic [ID_W-1:0]   id_q;
    logic [LEN_W-1:0]  len_q;
    burst_e            burst_q;
    logic [ADDR_W-1:0] addr_q;
    logic [LEN_W-1:0]  beat_q;                             // beats already sent
    logic              err_q;                              // earlier beat hit a hole
    logic              ar_fire;
    logic              r_fire;
    logic              beat_err;
    logic              last;

    assign ar_ready = (state_q == RD_IDLE);
    assign r_valid  = (state_q == RD_DATA);

    assign ar_fire = ar_valid && ar_ready;
    assign r_fire  = r_valid && r_ready;

    assign last     = r_valid && (beat_q == len_q);
    assign beat_err = burst_illegal(burst_q) || rd_illegal;

    always_comb begin
        state_d = state_q;
        case (state_q)
            RD_IDLE: if (ar_fire) state_d = RD_DATA;
            RD_DATA: if (r_fire && last) state_d = RD_IDLE;
            default: state_d = RD_IDLE;
        endcase
    end

    always_ff @(posedge clk or negedge STATUS_SLAVE_RSTN_SYNC) begin
        if (!STATUS_SLAVE_RSTN_SYNC) begin
            state_q <= RD_IDLE;
            beat_q  <= '0;
            err_q   <= 1'b0;
        end else begin
            state_q <= state_d;
            if (ar_fire) begin
                beat_q <= '0;
                err_q  <= 1'b0;
            end else if (r_fire) begin
                beat_q <= beat_q + 1'b1;
                if (beat_err) begin
                    err_q <= 1'b1;
                end
            end
        end
    end

    // request context
    always_ff @(posedge clk) begin
        if (ar_fire) begin
            id_q    <= ar.id;
            len_q   <= ar.len;
            burst_q <= ar.burst;
            addr_q  <= ar.addr;
        end else if (r_fire && burst_q == INCR) begin
            addr_q  <= addr_q + 1'b1;
        end
    end

    assign rd_addr = addr_q;                               // held while r_ready low

    assign r = '{
        id:   id_q,
        data: rd_data,
        resp: (beat_err || err_q) ? SLVERR : OKAY,
        last: last
    };

endmodule

// ==== logic/status_wr_channel.sv ====
`timescale 1ns/10ps

module status_wr_channel (
    input  logic                clk,
    input  logic                STATUS_SLAVE_RSTN_SYNC,
    input  status_pkg::aw_t     aw,
    input  logic                aw_valid,
    output logic                aw_ready,
    input  status_pkg::w_t      w,
    input  logic                w_valid,
    output logic                w_ready,
    output status_pkg::b_t      b,
    output logic                b_valid,
    input  logic                b_ready,
    output status_pkg::reg_wr_t reg_wr,
    input  logic                wr_illegal
);

    import status_pkg::*;

    wr_state_e         state_q;
    wr_state_e         state_d;
    logic [ID_W-1:0]   id_q;
    burst_e            burst_q;
    logic [ADDR_W-1:0] addr_q;
    logic              err_q;                              // sticky over the burst
    logic              aw_fire;
    logic              w_fire;
    logic              b_fire;

    assign aw_ready = (state_q == WR_IDLE);
    assign w_ready  = (state_q == WR_DATA);
    assign b_valid  = (state_q == WR_RESP);

    assign aw_fire = aw_valid && aw_ready;
    assign w_fire  = w_valid && w_ready;
    assign b_fire  = b_valid && b_ready;

    always_comb begin
        state_d = state_q;
        case (state_q)
            WR_IDLE: if (aw_fire) state_d = WR_DATA;
            WR_DATA: if (w_fire && w.last) state_d = WR_RESP;  // length ignored, last ends it
            WR_RESP: if (b_fire) state_d = WR_IDLE;
            default: state_d = WR_IDLE;
        endcase
    end

    always_ff @(posedge clk or negedge STATUS_SLAVE_RSTN_SYNC) begin
        if (!STATUS_SLAVE_RSTN_SYNC) begin
            state_q <= WR_IDLE;
            err_q   <= 1'b0;
        end else begin
            state_q <= state_d;
            if (aw_fire) begin
                err_q <= burst_illegal(aw.burst);            // wrap/reserved fail up front
            end else if (w_fire && wr_illegal) begin
                err_q <= 1'b1;
            end
        end
    end

    // burst context, only meaningful while a burst is open
    always_ff @(posedge clk) begin
        if (aw_fire) begin
            id_q    <= aw.id;
            burst_q <= aw.burst;
            addr_q  <= aw.addr;
        end else if (w_fire && burst_q == INCR) begin
            addr_q  <= addr_q + 1'b1;                        // one register per beat
        end
    end

    assign reg_wr = '{
        valid: w_fire && !burst_illegal(burst_q),            // bad bursts touch nothing
        addr:  addr_q,
        data:  w.data,
        strb:  w.strb
    };

    assign b = '{
        id:   id_q,
        resp: err_q ? SLVERR : OKAY
    };

endmodule

// ==== logic/status_pkg.sv ====
package status_pkg;

    localparam int ID_W   = 4;
    localparam int ADDR_W = 32;
    localparam int DATA_W = 32;
    localparam int STRB_W = DATA_W / 8;
    localparam int LEN_W  = 8;

    localparam int MAC_HI_PAD = 16;                       // zero bits above mac[47:32] on reads
    localparam logic [DATA_W-1:0] UNMAPPED_DATA = '1;     // read data of illegal addresses

    typedef enum logic [1:0] {
        FIXED    = 2'b00,
        INCR     = 2'b01,
        WRAP     = 2'b10,
        RESERVED = 2'b11
    } burst_e;

    typedef enum logic [1:0] {
        OKAY   = 2'b00,
        SLVERR = 2'b10
    } resp_e;

    typedef enum logic [ADDR_W-1:0] {
        AXI_RST_STATUS = 32'h0000_0000,                   // ro, {master, slave} reset done
        AXI_RESET      = 32'h0000_0001,                   // wo, reset pulses
        UID_HIGH       = 32'h0000_0002,
        UID_MIDDLE     = 32'h0000_0003,
        UID_LOW        = 32'h0000_0004,
        POWER_STATUS   = 32'h0000_0005,                   // rw, [7:0] only
        POWER_RESET    = 32'h0000_0006,                   // wo, pulse
        MAC_HIGH       = 32'h0000_0007,                   // rw, mac[47:32]
        MAC_LOW        = 32'h0000_0008,                   // rw, mac[31:0]
        DEV_IP         = 32'h0000_0009,
        HOST_IP        = 32'h0000_000A
    } reg_addr_e;

    typedef enum logic [1:0] {
        WR_IDLE,
        WR_DATA,
        WR_RESP
    } wr_state_e;

    typedef enum logic {
        RD_IDLE,
        RD_DATA
    } rd_state_e;

    typedef struct packed {
        logic [ID_W-1:0]   id;
        logic [ADDR_W-1:0] addr;
        burst_e            burst;
    } aw_t;

    typedef struct packed {
        logic [DATA_W-1:0] data;
        logic [STRB_W-1:0] strb;
        logic              last;
    } w_t;

    typedef struct packed {
        logic [ID_W-1:0] id;
        resp_e           resp;
    } b_t;

    typedef struct packed {
        logic [ID_W-1:0]   id;
        logic [ADDR_W-1:0] addr;
        logic [LEN_W-1:0]  len;                           // beats minus one
        burst_e            burst;
    } ar_t;

    typedef struct packed {
        logic [ID_W-1:0]   id;
        logic [DATA_W-1:0] data;
        resp_e             resp;
        logic              last;
    } r_t;

    typedef struct packed {
        logic              valid;                         // one accepted W beat
        logic [ADDR_W-1:0] addr;
        logic [DATA_W-1:0] data;
        logic [STRB_W-1:0] strb;
    } reg_wr_t;

    typedef struct packed {
        logic [15:0] master_rstn_status;
        logic [15:0] slave_rstn_status;
        logic [31:0] uid_high;
        logic [31:0] uid_middle;
        logic [31:0] uid_low;
    } sys_status_t;

    typedef struct packed {
        logic [47:0] mac;
        logic [31:0] ip;
        logic [31:0] host_ip;
    } net_cfg_t;

    function automatic logic burst_illegal(input burst_e burst);
        return !(burst inside {FIXED, INCR});
    endfunction

    function automatic logic addr_readable(input logic [ADDR_W-1:0] addr);
        case (addr)
            AXI_RST_STATUS, UID_HIGH, UID_MIDDLE, UID_LOW, POWER_STATUS,
            MAC_HIGH, MAC_LOW, DEV_IP, HOST_IP: return 1'b1;
            default: return 1'b0;
        endcase
    endfunction

    function automatic logic addr_writable(input logic [ADDR_W-1:0] addr);
        case (addr)
            AXI_RESET, POWER_STATUS, POWER_RESET, MAC_HIGH, MAC_LOW,
            DEV_IP, HOST_IP: return 1'b1;
            default: return 1'b0;
        endcase
    endfunction

endpackage
